/* common/rv_decode_pkg.sv */
/*
  RV64 decoder shared definitions
  Widths, the function and immediate-kind encodings, the instruction
  word union with its register and immediate views, and the control
  and command records passed between the decode stages
*/

`default_nettype none

package rv_decode_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int XLEN     = 64;  // Data width
  localparam int ILEN     = 32;  // Instruction width
  localparam int NUM_REGS = 32;  // Integer register file only

  localparam bit EN_MUL_DEF = 1'b1;  // M extension on by default

  typedef logic [4:0]          reg_idx_t;
  typedef logic [NUM_REGS-1:0] reg_mask_t;
  typedef logic [ILEN-1:0]     instr_word_t;

  //////////////////////////////////////////////////
  // Instruction word views
  //////////////////////////////////////////////////

  // R-type field split
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } instr_r_t;

  // Immediate field split
  typedef struct packed {
    logic [19:0] imm_up;  // Bits 31:12, U/J upper field
    logic [4:0]  imm_lo;  // Bits 11:7, S/B low part
    logic [6:0]  opcode;
  } instr_imm_t;

  typedef union packed {
    instr_r_t   rfmt;
    instr_imm_t ifmt;
  } instr_u;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // INVALID sits at zero so a cleared command decodes as illegal
  typedef enum logic [7:0] {
    INVALID = 8'd0,
    // Upper immediate and jumps
    LUI, AUIPC, JAL, JALR,
    // Branches
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    // Loads and stores
    LB, LH, LW, LD, LBU, LHU, LWU,
    SB, SH, SW, SD,
    // Register-immediate
    ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
    SLLI, SRLI, SRAI,
    // Register-register
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    // 32-bit word ops
    ADDIW, SLLIW, SRLIW, SRAIW,
    ADDW, SUBW, SLLW, SRLW, SRAW,
    // M extension
    MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
    MULW, DIVW, DIVUW, REMW, REMUW
  } func_t;

  typedef enum logic [2:0] {
    NONE,
    IIMM,  // I-type, sign-extended
    SIMM,  // Store offset
    BIMM,  // Branch offset
    UIMM,  // Upper immediate
    JIMM,  // Jump offset
    AIMM   // Shift amount, 6 bits
  } imm_sel_t;

  //////////////////////////////////////////////////
  // Stage records
  //////////////////////////////////////////////////

  // Output of the match table
  typedef struct packed {
    func_t    func;
    imm_sel_t imm_sel;
    logic     rd_used;
    logic     rs1_used;
    logic     rs2_used;
    logic     jump;
  } decode_ctrl_t;

  // Registered command seen by the consumer
  typedef struct packed {
    func_t           func;
    reg_idx_t        rd;
    reg_idx_t        rs1;
    reg_idx_t        rs2;
    logic [XLEN-1:0] imm;
    logic            jump;     // Branch or jump
    reg_mask_t       reg_req;  // Registers this command touches
  } decoded_instr_t;

endpackage

`default_nettype wire

/* hdl/fetch_latch.sv */
/*
  Fetch latch
  Input register of the decoder. Captures the instruction word
  whenever its strobe is high and carries the strobe one cycle on
*/

`default_nettype none

module fetch_latch (
  input  logic                        clk_i,
  input  logic                        i_rst_n,
  input  logic                        i_valid,
  input  rv_decode_pkg::instr_word_t  i_instr,
  output logic                        o_valid,
  output rv_decode_pkg::instr_u       o_instr
);

  // Strobe follows the input every cycle
  always_ff @(posedge clk_i or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  // Word only moves on a valid cycle
  always_ff @(posedge clk_i or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_instr <= '0;
    end else if (i_valid) begin
      o_instr <= i_instr;  // Raw word into the union
    end
  end

endmodule

`default_nettype wire

/* decode/func_matcher.sv */
/*
  Function matcher
  Mask/match table over the RV64I and M instruction encodings.
  The matching row gives the function, the immediate kind, which
  register fields are live and whether the instruction can jump.
  No match gives INVALID with everything else cleared
*/

`default_nettype none

module func_matcher #(
  parameter bit EN_MUL = rv_decode_pkg::EN_MUL_DEF
) (
  input  rv_decode_pkg::instr_u        i_instr,
  output rv_decode_pkg::decode_ctrl_t  o_ctrl
);

  import rv_decode_pkg::*;

  //////////////////////////////////////////////////
  // Table format
  //////////////////////////////////////////////////

  // Masks per format class
  localparam instr_word_t MASK_OP = 32'h0000_007F;  // Opcode only
  localparam instr_word_t MASK_F3 = 32'h0000_707F;  // Opcode and funct3
  localparam instr_word_t MASK_SH = 32'hFC00_707F;  // 64-bit shift, funct6
  localparam instr_word_t MASK_R  = 32'hFE00_707F;  // Full funct7

  // Register use as {rd, rs1, rs2}
  localparam logic [2:0] RG_D   = 3'b100;
  localparam logic [2:0] RG_DS1 = 3'b110;
  localparam logic [2:0] RG_S12 = 3'b011;
  localparam logic [2:0] RG_ALL = 3'b111;

  localparam int NUM_BASE = 49;
  localparam int NUM_MUL  = 13;

  typedef struct packed {
    instr_word_t mask;
    instr_word_t match;
    func_t       func;
    imm_sel_t    imm_sel;
    logic [2:0]  regs;
    logic        jump;
  } row_t;

  localparam decode_ctrl_t NO_CTRL = '{INVALID, NONE, 1'b0, 1'b0, 1'b0, 1'b0};

  localparam row_t BASE_TBL [NUM_BASE] = '{
    '{MASK_OP, 32'h0000_0037, LUI,   UIMM, RG_D,   1'b0},
    '{MASK_OP, 32'h0000_0017, AUIPC, UIMM, RG_D,   1'b0},
    '{MASK_OP, 32'h0000_006F, JAL,   JIMM, RG_D,   1'b1},
    '{MASK_F3, 32'h0000_0067, JALR,  IIMM, RG_DS1, 1'b1},
    '{MASK_F3, 32'h0000_0063, BEQ,   BIMM, RG_S12, 1'b1},
    '{MASK_F3, 32'h0000_1063, BNE,   BIMM, RG_S12, 1'b1},
    '{MASK_F3, 32'h0000_4063, BLT,   BIMM, RG_S12, 1'b1},
    '{MASK_F3, 32'h0000_5063, BGE,   BIMM, RG_S12, 1'b1},
    '{MASK_F3, 32'h0000_6063, BLTU,  BIMM, RG_S12, 1'b1},
    '{MASK_F3, 32'h0000_7063, BGEU,  BIMM, RG_S12, 1'b1},
    '{MASK_F3, 32'h0000_0003, LB,    IIMM, RG_DS1, 1'b0},
    '{MASK_F3, 32'h0000_1003, LH,    IIMM, RG_DS1, 1'b0},
    '{MASK_F3, 32'h0000_2003, LW,    IIMM, RG_DS1, 1'b0},
    '{MASK_F3, 32'h0000_3003, LD,    IIMM, RG_DS1, 1'b0},
    '{MASK_F3, 32'h0000_4003, LBU,   IIMM, RG_DS1, 1'b0},
    '{MASK_F3, 32'h0000_5003, LHU,   IIMM, RG_DS1, 1'b0},
    '{MASK_F3, 32'h0000_6003, LWU,   IIMM, RG_DS1, 1'b0},
    '{MASK_F3, 32'h0000_0023, SB,    SIMM, RG_S12, 1'b0},
    '{MASK_F3, 32'h0000_1023, SH,    SIMM, RG_S12, 1'b0},
    '{MASK_F3, 32'h0000_2023, SW,    SIMM, RG_S12, 1'b0},
    '{MASK_F3, 32'h0000_3023, SD,    SIMM, RG_S12, 1'b0},
    '{MASK_F3, 32'h0000_0013, ADDI,  IIMM, RG_DS1, 1'b0},
    '{MASK_F3, 32'h0000_2013, SLTI,  IIMM, RG_DS1, 1'b0},
    '{MASK_F3, 32'h0000_3013, SLTIU, IIMM, RG_DS1, 1'b0},
    '{MASK_F3, 32'h0000_4013, XORI,  IIMM, RG_DS1, 1'b0},
    '{MASK_F3, 32'h0000_6013, ORI,   IIMM, RG_DS1, 1'b0},
    '{MASK_F3, 32'h0000_7013, ANDI,  IIMM, RG_DS1, 1'b0},
    '{MASK_SH, 32'h0000_1013, SLLI,  AIMM, RG_DS1, 1'b0},
    '{MASK_SH, 32'h0000_5013, SRLI,  AIMM, RG_DS1, 1'b0},
    '{MASK_SH, 32'h4000_5013, SRAI,  AIMM, RG_DS1, 1'b0},
    '{MASK_R,  32'h0000_0033, ADD,   NONE, RG_ALL, 1'b0},
    '{MASK_R,  32'h4000_0033, SUB,   NONE, RG_ALL, 1'b0},
    '{MASK_R,  32'h0000_1033, SLL,   NONE, RG_ALL, 1'b0},
    '{MASK_R,  32'h0000_2033, SLT,   NONE, RG_ALL, 1'b0},
    '{MASK_R,  32'h0000_3033, SLTU,  NONE, RG_ALL, 1'b0},
    '{MASK_R,  32'h0000_4033, XOR,   NONE, RG_ALL, 1'b0},
    '{MASK_R,  32'h0000_5033, SRL,   NONE, RG_ALL, 1'b0},
    '{MASK_R,  32'h4000_5033, SRA,   NONE, RG_ALL, 1'b0},
    '{MASK_R,  32'h0000_6033, OR,    NONE, RG_ALL, 1'b0},
    '{MASK_R,  32'h0000_7033, AND,   NONE, RG_ALL, 1'b0},
    '{MASK_F3, 32'h0000_001B, ADDIW, IIMM, RG_DS1, 1'b0},
    '{MASK_R,  32'h0000_101B, SLLIW, AIMM, RG_DS1, 1'b0},  // 5-bit shamt
    '{MASK_R,  32'h0000_501B, SRLIW, AIMM, RG_DS1, 1'b0},
    '{MASK_R,  32'h4000_501B, SRAIW, AIMM, RG_DS1, 1'b0},
    '{MASK_R,  32'h0000_003B, ADDW,  NONE, RG_ALL, 1'b0},
    '{MASK_R,  32'h4000_003B, SUBW,  NONE, RG_ALL, 1'b0},
    '{MASK_R,  32'h0000_103B, SLLW,  NONE, RG_ALL, 1'b0},
    '{MASK_R,  32'h0000_503B, SRLW,  NONE, RG_ALL, 1'b0},
    '{MASK_R,  32'h4000_503B, SRAW,  NONE, RG_ALL, 1'b0}
  };

  decode_ctrl_t base_ctrl;
  decode_ctrl_t mul_ctrl;
  logic         mul_hit;

  function automatic decode_ctrl_t row_ctrl(input row_t r);
    decode_ctrl_t c;
    c.func     = r.func;
    c.imm_sel  = r.imm_sel;
    c.rd_used  = r.regs[2];
    c.rs1_used = r.regs[1];
    c.rs2_used = r.regs[0];
    c.jump     = r.jump;
    return c;
  endfunction

  // Rows are disjoint, at most one hits
  always_comb begin
    base_ctrl = NO_CTRL;
    for (int k = 0; k < NUM_BASE; k++) begin
      if ((i_instr & BASE_TBL[k].mask) == BASE_TBL[k].match) begin
        base_ctrl = row_ctrl(BASE_TBL[k]);
      end
    end
  end

  //////////////////////////////////////////////////
  // M extension rows
  //////////////////////////////////////////////////

  if (EN_MUL) begin : g_mul
    localparam row_t MUL_TBL [NUM_MUL] = '{
      '{MASK_R, 32'h0200_0033, MUL,    NONE, RG_ALL, 1'b0},
      '{MASK_R, 32'h0200_1033, MULH,   NONE, RG_ALL, 1'b0},
      '{MASK_R, 32'h0200_2033, MULHSU, NONE, RG_ALL, 1'b0},
      '{MASK_R, 32'h0200_3033, MULHU,  NONE, RG_ALL, 1'b0},
      '{MASK_R, 32'h0200_4033, DIV,    NONE, RG_ALL, 1'b0},
      '{MASK_R, 32'h0200_5033, DIVU,   NONE, RG_ALL, 1'b0},
      '{MASK_R, 32'h0200_6033, REM,    NONE, RG_ALL, 1'b0},
      '{MASK_R, 32'h0200_7033, REMU,   NONE, RG_ALL, 1'b0},
      '{MASK_R, 32'h0200_003B, MULW,   NONE, RG_ALL, 1'b0},
      '{MASK_R, 32'h0200_403B, DIVW,   NONE, RG_ALL, 1'b0},
      '{MASK_R, 32'h0200_503B, DIVUW,  NONE, RG_ALL, 1'b0},
      '{MASK_R, 32'h0200_603B, REMW,   NONE, RG_ALL, 1'b0},
      '{MASK_R, 32'h0200_703B, REMUW,  NONE, RG_ALL, 1'b0}
    };

    always_comb begin
      mul_hit  = 1'b0;
      mul_ctrl = NO_CTRL;
      for (int k = 0; k < NUM_MUL; k++) begin
        if ((i_instr & MUL_TBL[k].mask) == MUL_TBL[k].match) begin
          mul_hit  = 1'b1;
          mul_ctrl = row_ctrl(MUL_TBL[k]);
        end
      end
    end
  end else begin : g_no_mul
    // funct7 of 01 matches no base row, so M words fall to INVALID
    assign mul_hit  = 1'b0;
    assign mul_ctrl = NO_CTRL;
  end

  assign o_ctrl = mul_hit ? mul_ctrl : base_ctrl;

endmodule

`default_nettype wire

/* decode/imm_gen.sv */
/*
  Immediate generator
  Builds every RV64 immediate form from the immediate view of the
  instruction word and passes on the one picked by the decoder
*/

`default_nettype none

module imm_gen (
  input  rv_decode_pkg::instr_u                 i_instr,
  input  rv_decode_pkg::imm_sel_t               i_imm_sel,
  output logic [rv_decode_pkg::XLEN-1:0]        o_imm
);

  import rv_decode_pkg::*;

  logic [19:0]     up;  // Instr bits 31:12
  logic [4:0]      lo;  // Instr bits 11:7
  logic [XLEN-1:0] iimm;
  logic [XLEN-1:0] simm;
  logic [XLEN-1:0] bimm;
  logic [XLEN-1:0] uimm;
  logic [XLEN-1:0] jimm;
  logic [XLEN-1:0] aimm;

  assign up = i_instr.ifmt.imm_up;
  assign lo = i_instr.ifmt.imm_lo;

  // Sign always comes from instr bit 31
  assign iimm = {{(XLEN-12){up[19]}}, up[19:8]};
  assign simm = {{(XLEN-12){up[19]}}, up[19:13], lo};
  assign bimm = {{(XLEN-13){up[19]}}, up[19], lo[0], up[18:13], lo[4:1], 1'b0};
  assign uimm = {{(XLEN-32){up[19]}}, up, 12'h000};
  assign jimm = {{(XLEN-21){up[19]}}, up[19], up[7:0], up[8], up[18:9], 1'b0};

  // Shift amount, unsigned
  assign aimm = {{(XLEN-6){1'b0}}, up[13:8]};

  always_comb begin
    case (i_imm_sel)
      IIMM:    o_imm = iimm;
      SIMM:    o_imm = simm;
      BIMM:    o_imm = bimm;
      UIMM:    o_imm = uimm;
      JIMM:    o_imm = jimm;
      AIMM:    o_imm = aimm;
      default: o_imm = '0;  // NONE and unused codes
    endcase
  end

endmodule

`default_nettype wire

/* hdl/decode_out_reg.sv */
/*
  Decode output register
  Picks the live register fields, builds the required-register mask
  and registers the finished command together with its strobe
*/

`default_nettype none

module decode_out_reg (
  input  logic                                  clk_i,
  input  logic                                  i_rst_n,
  input  logic                                  i_valid,
  input  rv_decode_pkg::instr_u                 i_instr,
  input  rv_decode_pkg::decode_ctrl_t           i_ctrl,
  input  logic [rv_decode_pkg::XLEN-1:0]        i_imm,
  output logic                                  o_valid,
  output rv_decode_pkg::decoded_instr_t         o_cmd
);

  import rv_decode_pkg::*;

  reg_idx_t       rd;
  reg_idx_t       rs1;
  reg_idx_t       rs2;
  reg_mask_t      reg_req;
  decoded_instr_t cmd_d;

  // Unused fields read as x0
  assign rd  = i_ctrl.rd_used  ? i_instr.rfmt.rd  : '0;
  assign rs1 = i_ctrl.rs1_used ? i_instr.rfmt.rs1 : '0;
  assign rs2 = i_ctrl.rs2_used ? i_instr.rfmt.rs2 : '0;

  // Jumps claim the whole file
  always_comb begin
    reg_req      = {NUM_REGS{i_ctrl.jump}};
    reg_req[rd]  = 1'b1;
    reg_req[rs1] = 1'b1;
    reg_req[rs2] = 1'b1;
  end

  always_comb begin
    cmd_d.func    = i_ctrl.func;
    cmd_d.rd      = rd;
    cmd_d.rs1     = rs1;
    cmd_d.rs2     = rs2;
    cmd_d.imm     = i_imm;
    cmd_d.jump    = i_ctrl.jump;
    cmd_d.reg_req = reg_req;
  end

  always_ff @(posedge clk_i or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
      o_cmd   <= '0;  // Decodes as INVALID
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_cmd <= cmd_d;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/rv_decode_top.sv */
/*
  RV64 instruction decoder, top level
  Input register, combinational decode and output register.
  Two cycles from input strobe to output strobe, no back-pressure
*/

`default_nettype none

module rv_decode_top #(
  parameter bit EN_MUL = rv_decode_pkg::EN_MUL_DEF  // M extension decode
) (
  input  logic                           clk_i,
  input  logic                           i_rst_n,
  input  logic                           i_valid,
  input  rv_decode_pkg::instr_word_t     i_instr,
  output logic                           o_valid,
  output rv_decode_pkg::decoded_instr_t  o_cmd
);

  import rv_decode_pkg::*;

  logic            fetch_valid;
  instr_u          fetch_instr;
  decode_ctrl_t    ctrl;
  logic [XLEN-1:0] imm;

  fetch_latch u_fetch (
    .clk_i   (clk_i),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_instr (i_instr),
    .o_valid (fetch_valid),
    .o_instr (fetch_instr)
  );

  func_matcher #(.EN_MUL(EN_MUL)) u_match (
    .i_instr (fetch_instr),
    .o_ctrl  (ctrl)
  );

  imm_gen u_imm (
    .i_instr   (fetch_instr),
    .i_imm_sel (ctrl.imm_sel),
    .o_imm     (imm)
  );

  decode_out_reg u_out (
    .clk_i   (clk_i),
    .i_rst_n (i_rst_n),
    .i_valid (fetch_valid),
    .i_instr (fetch_instr),
    .i_ctrl  (ctrl),
    .i_imm   (imm),
    .o_valid (o_valid),
    .o_cmd   (o_cmd)
  );

endmodule

`default_nettype wire

/* verification/rv_decode_chk.sv */
/*
  Decoder protocol checker
  Bound to the decoder top level. Watches the output strobe timing
  and basic consistency of the registered command
*/

`default_nettype none

module rv_decode_chk (
  input logic                           clk_i,
  input logic                           i_rst_n,
  input logic                           i_valid,
  input logic                           i_out_valid,
  input rv_decode_pkg::decoded_instr_t  i_out_cmd
);

  import rv_decode_pkg::*;

  // Strobe held low through reset
  a_reset_quiet: assert property (@(posedge clk_i) !i_rst_n |-> !i_out_valid)
    else $error("output strobe high during reset");

  // Fixed two-cycle pipe
  a_latency: assert property (@(posedge clk_i) disable iff (!i_rst_n)
    i_out_valid == $past(i_valid, 2))
    else $error("output strobe not two cycles after input strobe");

  a_invalid_no_jump: assert property (@(posedge clk_i) disable iff (!i_rst_n)
    (i_out_valid && i_out_cmd.func == INVALID) |-> !i_out_cmd.jump)
    else $error("illegal command flagged as jump");

  a_rd_in_mask: assert property (@(posedge clk_i) disable iff (!i_rst_n)
    i_out_valid |-> i_out_cmd.reg_req[i_out_cmd.rd])
    else $error("destination register missing from mask");

endmodule

bind rv_decode_top rv_decode_chk chk_i (
  .clk_i       (clk_i),
  .i_rst_n     (i_rst_n),
  .i_valid     (i_valid),
  .i_out_valid (o_valid),
  .i_out_cmd   (o_cmd)
);

`default_nettype wire

/* verification/rv_decode_tb.sv */
/*
  Directed testbench for the RV64 decoder
  Encodes instruction words from field values, pushes them through
  the two-stage pipe and checks every field of the command against
  values worked out from the ISA encoding rules
*/

`default_nettype none

module rv_decode_tb;

  import rv_decode_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int ITEM_COUNT   = 38;  // Sum of items over all tests
  localparam int CYCLE_LIMIT  = ITEM_COUNT * 4 + RESET_CYCLES;

  logic           clk_i = 1'b0;
  logic           i_rst_n;
  logic           i_valid;
  instr_word_t    i_instr;
  logic           o_valid;
  decoded_instr_t o_cmd;

  int          errors    = 0;
  int          cycles    = 0;
  logic [31:0] lcg_state = 32'h2a96;

  always #4 clk_i = ~clk_i;

  rv_decode_top #(.EN_MUL(1'b1)) dut_i (
    .clk_i   (clk_i),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_instr (i_instr),
    .o_valid (o_valid),
    .o_cmd   (o_cmd)
  );

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic reg_idx_t rand_reg();
    return reg_idx_t'(next_rand() >> 16);  // Upper bits mix better
  endfunction

  // Negative value in -1 .. -2^(bits-1)
  function automatic longint rand_neg(input int bits);
    return -64'sd1 - (longint'(next_rand()) % (64'sd1 <<< (bits - 1)));
  endfunction

  function automatic instr_word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, rs1,
                                        input logic [2:0] f3, input reg_idx_t rd,
                                        input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic instr_word_t enc_i(input longint imm, input reg_idx_t rs1,
                                        input logic [2:0] f3, input reg_idx_t rd,
                                        input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic instr_word_t enc_s(input longint imm, input reg_idx_t rs2, rs1,
                                        input logic [2:0] f3, input logic [6:0] op);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
  endfunction

  function automatic instr_word_t enc_b(input longint imm, input reg_idx_t rs2, rs1,
                                        input logic [2:0] f3, input logic [6:0] op);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
  endfunction

  function automatic instr_word_t enc_u(input longint imm, input reg_idx_t rd,
                                        input logic [6:0] op);
    return {imm[31:12], rd, op};
  endfunction

  function automatic instr_word_t enc_j(input longint imm, input reg_idx_t rd,
                                        input logic [6:0] op);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
  endfunction

  // Expected command, jumps claim every register
  function automatic decoded_instr_t make_cmd(input func_t f, input reg_idx_t rd, rs1, rs2,
                                              input longint imm, input logic jump);
    decoded_instr_t c;
    reg_mask_t      req;
    if (jump) begin
      req = '1;
    end else begin
      req = (reg_mask_t'(1) << rd) | (reg_mask_t'(1) << rs1) | (reg_mask_t'(1) << rs2);
    end
    c = '{f, rd, rs1, rs2, imm, jump, req};
    return c;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic compare_func(input string name, input func_t got, input func_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_imm(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_mask(input string name, input reg_mask_t got, input reg_mask_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_cmd(input string tag, input decoded_instr_t exp);
    compare_func({tag, " o_cmd.func"}, o_cmd.func, exp.func);
    compare_reg({tag, " o_cmd.rd"}, o_cmd.rd, exp.rd);
    compare_reg({tag, " o_cmd.rs1"}, o_cmd.rs1, exp.rs1);
    compare_reg({tag, " o_cmd.rs2"}, o_cmd.rs2, exp.rs2);
    compare_imm({tag, " o_cmd.imm"}, o_cmd.imm, exp.imm);
    compare_bit({tag, " o_cmd.jump"}, o_cmd.jump, exp.jump);
    compare_mask({tag, " o_cmd.reg_req"}, o_cmd.reg_req, exp.reg_req);
  endtask

  // One word in, result checked two cycles after the sampling edge
  task automatic send_one(input string tag, input instr_word_t word, input decoded_instr_t exp);
    @(posedge clk_i);
    i_valid <= 1'b1;
    i_instr <= word;
    @(posedge clk_i);  // Sampling edge
    i_valid <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);  // Output stable here
    compare_bit({tag, " o_valid"}, o_valid, 1'b1);
    check_cmd(tag, exp);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic alu_tests();
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    longint   imm;
    rd  = rand_reg();
    rs1 = rand_reg();
    rs2 = rand_reg();
    imm = -64'sd5;
    send_one("ADDI", enc_i(imm, rs1, 3'd0, rd, 7'h13), make_cmd(ADDI, rd, rs1, 5'd0, imm, 1'b0));
    imm = rand_neg(12);
    send_one("SLTIU", enc_i(imm, rs1, 3'd3, rd, 7'h13),
             make_cmd(SLTIU, rd, rs1, 5'd0, imm, 1'b0));
    send_one("ADD", enc_r(7'h00, rs2, rs1, 3'd0, rd, 7'h33),
             make_cmd(ADD, rd, rs1, rs2, 64'sd0, 1'b0));
    send_one("SUB", enc_r(7'h20, rs2, rs1, 3'd0, rd, 7'h33),
             make_cmd(SUB, rd, rs1, rs2, 64'sd0, 1'b0));
    send_one("ADDW", enc_r(7'h00, rs2, rs1, 3'd0, rd, 7'h3B),
             make_cmd(ADDW, rd, rs1, rs2, 64'sd0, 1'b0));
  endtask

  task automatic mem_tests();
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    longint   imm;
    rd  = rand_reg();
    rs1 = rand_reg();
    rs2 = rand_reg();
    imm = rand_neg(12);
    send_one("LB", enc_i(imm, rs1, 3'd0, rd, 7'h03), make_cmd(LB, rd, rs1, 5'd0, imm, 1'b0));
    send_one("LWU", enc_i(64'sd2047, rs1, 3'd6, rd, 7'h03),
             make_cmd(LWU, rd, rs1, 5'd0, 64'sd2047, 1'b0));
    imm = rand_neg(12);
    send_one("LD", enc_i(imm, rs1, 3'd3, rd, 7'h03), make_cmd(LD, rd, rs1, 5'd0, imm, 1'b0));
    imm = rand_neg(12);
    send_one("SW", enc_s(imm, rs2, rs1, 3'd2, 7'h23), make_cmd(SW, 5'd0, rs1, rs2, imm, 1'b0));
    send_one("SD", enc_s(64'sd1365, rs2, rs1, 3'd3, 7'h23),
             make_cmd(SD, 5'd0, rs1, rs2, 64'sd1365, 1'b0));
  endtask

  task automatic flow_tests();
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    longint   imm;
    rd  = rand_reg();
    rs1 = rand_reg();
    rs2 = rand_reg();
    imm = rand_neg(12) <<< 1;  // Even offsets only
    send_one("BEQ", enc_b(imm, rs2, rs1, 3'd0, 7'h63), make_cmd(BEQ, 5'd0, rs1, rs2, imm, 1'b1));
    send_one("BGEU", enc_b(64'sd1362, rs2, rs1, 3'd7, 7'h63),
             make_cmd(BGEU, 5'd0, rs1, rs2, 64'sd1362, 1'b1));
    imm = rand_neg(20) <<< 1;
    send_one("JAL", enc_j(imm, rd, 7'h6F), make_cmd(JAL, rd, 5'd0, 5'd0, imm, 1'b1));
    send_one("JALR", enc_i(64'sd2032, rs1, 3'd0, rd, 7'h67),
             make_cmd(JALR, rd, rs1, 5'd0, 64'sd2032, 1'b1));
  endtask

  task automatic upper_shift_tests();
    reg_idx_t rd;
    reg_idx_t rs1;
    longint   imm;
    rd  = rand_reg();
    rs1 = rand_reg();
    imm = rand_neg(20) <<< 12;  // Bit 31 set
    send_one("LUI", enc_u(imm, rd, 7'h37), make_cmd(LUI, rd, 5'd0, 5'd0, imm, 1'b0));
    send_one("AUIPC", enc_u(64'sh7ABCD000, rd, 7'h17),
             make_cmd(AUIPC, rd, 5'd0, 5'd0, 64'sh7ABCD000, 1'b0));
    send_one("SLLI", enc_i(64'sd43, rs1, 3'd1, rd, 7'h13),
             make_cmd(SLLI, rd, rs1, 5'd0, 64'sd43, 1'b0));
    // funct6 of 010000 above a shamt of 57
    send_one("SRAI", enc_i(64'sd1024 + 64'sd57, rs1, 3'd5, rd, 7'h13),
             make_cmd(SRAI, rd, rs1, 5'd0, 64'sd57, 1'b0));
    send_one("SRLIW", enc_i(64'sd19, rs1, 3'd5, rd, 7'h1B),
             make_cmd(SRLIW, rd, rs1, 5'd0, 64'sd19, 1'b0));
    send_one("SRAIW", enc_i(64'sd1024 + 64'sd19, rs1, 3'd5, rd, 7'h1B),
             make_cmd(SRAIW, rd, rs1, 5'd0, 64'sd19, 1'b0));
  endtask

  task automatic mul_tests();
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    rd  = rand_reg();
    rs1 = rand_reg();
    rs2 = rand_reg();
    send_one("MUL", enc_r(7'h01, rs2, rs1, 3'd0, rd, 7'h33),
             make_cmd(MUL, rd, rs1, rs2, 64'sd0, 1'b0));
    send_one("MULHSU", enc_r(7'h01, rs2, rs1, 3'd2, rd, 7'h33),
             make_cmd(MULHSU, rd, rs1, rs2, 64'sd0, 1'b0));
    send_one("DIVU", enc_r(7'h01, rs2, rs1, 3'd5, rd, 7'h33),
             make_cmd(DIVU, rd, rs1, rs2, 64'sd0, 1'b0));
    send_one("REMW", enc_r(7'h01, rs2, rs1, 3'd6, rd, 7'h3B),
             make_cmd(REMW, rd, rs1, rs2, 64'sd0, 1'b0));
  endtask

  task automatic illegal_tests();
    decoded_instr_t none_cmd;
    reg_idx_t       rd;
    reg_idx_t       rs1;
    reg_idx_t       rs2;
    none_cmd = make_cmd(INVALID, 5'd0, 5'd0, 5'd0, 64'sd0, 1'b0);
    rd  = rand_reg();
    rs1 = rand_reg();
    rs2 = rand_reg();
    send_one("zero word", 32'h0000_0000, none_cmd);
    send_one("FADD.S", enc_r(7'h00, rs2, rs1, 3'd0, rd, 7'h53), none_cmd);
    send_one("CSRRW", enc_i(64'sh300, rs1, 3'd1, rd, 7'h73), none_cmd);
    send_one("ECALL", 32'h0000_0073, none_cmd);
  endtask

  // Back-to-back items with gaps, strobe must follow two cycles later
  task automatic burst_test();
    logic [9:0]     pattern;
    decoded_instr_t exp [10];
    instr_word_t    word [10];
    reg_idx_t       rd;
    reg_idx_t       rs1;
    longint         imm;
    pattern = 10'b01_1101_0111;
    for (int k = 0; k < 10; k++) begin
      rd      = rand_reg();
      rs1     = rand_reg();
      imm     = rand_neg(12);
      word[k] = enc_i(imm, rs1, 3'd0, rd, 7'h13);
      exp[k]  = make_cmd(ADDI, rd, rs1, 5'd0, imm, 1'b0);
    end
    for (int k = 0; k < 12; k++) begin
      @(posedge clk_i);
      if (k < 10) begin
        i_valid <= pattern[k];
        i_instr <= word[k];
      end else begin
        i_valid <= 1'b0;
      end
      @(negedge clk_i);
      if (k >= 2) begin
        compare_bit("burst o_valid", o_valid, pattern[k-2]);
        if (pattern[k-2]) begin
          check_cmd("burst", exp[k-2]);
        end
      end
    end
  endtask

  initial begin
    i_rst_n = 1'b0;
    i_valid = 1'b0;
    i_instr = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    i_rst_n <= 1'b1;
    alu_tests();
    mem_tests();
    flow_tests();
    upper_shift_tests();
    mul_tests();
    illegal_tests();
    burst_test();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
common/rv_decode_pkg.sv
hdl/fetch_latch.sv
decode/func_matcher.sv
decode/imm_gen.sv
hdl/decode_out_reg.sv
hdl/rv_decode_top.sv
verification/rv_decode_chk.sv
verification/rv_decode_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert -f compile.f --top-module rv_decode_tb -Mdir obj_dir
	./obj_dir/Vrv_decode_tb > sim.log 2>&1; cat sim.log
	grep -q "sim passed" sim.log
	! grep -q "sim failed" sim.log

clean:
	rm -rf obj_dir sim.log
